// File: verif/dmem_axil_tests.txt
// op addr wdata strb exp_rdata exp_resp raddr, all hex
// op 0 read, 1 write, 2 write W late, 3 write AW late, 4 write and read at raddr
0001 0010 1234 0003 0000 0000 0000
0000 0010 0000 0000 1234 0000 0000
0002 0020 abcd 0003 0000 0000 0000
0000 0020 0000 0000 abcd 0000 0000
0001 0020 5566 0002 0000 0000 0000
0000 0020 0000 0000 55cd 0000 0000
0003 0020 7788 0001 0000 0000 0000
0000 0020 0000 0000 5588 0000 0000
0001 0101 beef 0003 0000 0000 0000
0000 0100 0000 0000 00be 0000 0000
0000 0102 0000 0000 ef00 0000 0000
0000 0101 0000 0000 beef 0000 0000
0002 fffe 1122 0003 0000 0000 0000
0000 fffe 0000 0000 1122 0000 0000
0001 ffff 9999 0003 0000 0002 0000
0000 ffff 0000 0000 0000 0002 0000
0000 fffe 0000 0000 1122 0000 0000
0004 0200 cafe 0003 1234 0000 0010
0000 0200 0000 0000 cafe 0000 0000
0004 0300 0f0f 0002 5588 0000 0020
0000 0300 0000 0000 0f00 0000 0000
0003 0021 aa55 0003 0000 0000 0000
0000 0020 0000 0000 55aa 0000 0000
0000 0022 0000 0000 5500 0000 0000
00ff 0000 0000 0000 0000 0000 0000

// File: vlog.f
+incdir+hdl
hdl/dmem_pkg.sv
hdl/dmem_req_if.sv
hdl/dmem_rsp_if.sv
hdl/axil_req_stage.sv
hdl/byte_mem16.sv
hdl/axil_rsp_stage.sv
hdl/dmem_axil_top.sv
verif/dmem_axil_props.sv
verif/dmem_axil_tb.sv

// File: Makefile
# Verilator build and run of the data memory testbench

VERILATOR ?= verilator
TOP       ?= dmem_axil_tb
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verif/dmem_axil_tb.sv
/*
 * testbench for the AXI4-Lite data memory
 * clock, reset, vector file stimulus, response checks,
 * cycle limit and closing summary
 */

`timescale 1ns/1ps
`include "dmem_defs.svh"

module dmem_axil_tb;

   // one vector is op, addr, wdata, strb, exp rdata, exp resp, read addr
   localparam int FIELDS    = 7;
   localparam int MAX_TESTS = 32;

   logic                       clk;
   logic                       rst;
   logic                       awvalid;
   logic                       awready;
   logic [`DMEM_ADDR_W-1:0]    awaddr;
   logic                       wvalid;
   logic                       wready;
   logic [`DMEM_DATA_W-1:0]    wdata;
   logic [`DMEM_DATA_W/8-1:0]  wstrb;
   logic                       bvalid;
   logic                       bready;
   dmem_pkg::axi_resp_e        bresp;
   logic                       arvalid;
   logic                       arready;
   logic [`DMEM_ADDR_W-1:0]    araddr;
   logic                       rvalid;
   logic                       rready;
   logic [`DMEM_DATA_W-1:0]    rdata;
   dmem_pkg::axi_resp_e        rresp;

   logic [15:0]                vec [0:FIELDS*MAX_TESTS-1];
   int                         ntests;
   int                         limit = 50;
   int                         cycles = 0;
   int                         seed = 6;
   int                         errors = 0;
   int                         pass_cnt = 0;
   int                         fail_cnt = 0;

   dmem_axil_top dmem_axil_top_i (
      .clk     (clk),
      .rst     (rst),
      .awvalid (awvalid),
      .awready (awready),
      .awaddr  (awaddr),
      .wvalid  (wvalid),
      .wready  (wready),
      .wdata   (wdata),
      .wstrb   (wstrb),
      .bvalid  (bvalid),
      .bready  (bready),
      .bresp   (bresp),
      .arvalid (arvalid),
      .arready (arready),
      .araddr  (araddr),
      .rvalid  (rvalid),
      .rready  (rready),
      .rdata   (rdata),
      .rresp   (rresp)
   );

   // handshake checks, with a look at the request path inside
   bind dmem_axil_top dmem_axil_props props_i (
      .clk        (clk),
      .rst        (rst),
      .awvalid    (awvalid),
      .awready    (awready),
      .awaddr     (awaddr),
      .wvalid     (wvalid),
      .wready     (wready),
      .wdata      (wdata),
      .wstrb      (wstrb),
      .bvalid     (bvalid),
      .bready     (bready),
      .bresp      (bresp),
      .arvalid    (arvalid),
      .arready    (arready),
      .araddr     (araddr),
      .rvalid     (rvalid),
      .rready     (rready),
      .rdata      (rdata),
      .rresp      (rresp),
      .req_valid  (req_i.valid),
      .space      (rsp_i.space),
      .last_grant (req_stage_i.last_grant)
   );

   // 4 ns period
   always #2 clk = ~clk;

   // run limit, set from the number of vectors
   always @(posedge clk) begin
      cycles++;
      if (cycles > limit) begin
         $display("timeout: no finish after %0d cycles, a response never came", cycles);
         $display("TESTS FAILED");
         $finish;
      end
   end

   task automatic report_mismatch(input string name, input logic [15:0] got,
                                  input logic [15:0] exp);
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
   endtask

   ////////////////////////////////////////////////////////////
   // one vector: drive beats and collect responses,
   // everything happens on the falling edge
   ////////////////////////////////////////////////////////////

   task automatic run_test(input int idx);
      logic [15:0] op;
      logic [15:0] addr;
      logic [15:0] wd;
      logic [15:0] strb;
      logic [15:0] exp_rd;
      logic [15:0] exp_rs;
      logic [15:0] raddr;
      logic        need_aw;
      logic        need_w;
      logic        need_ar;
      logic        need_b;
      logic        need_r;
      int          aw_dly;
      int          w_dly;
      int          b_stall;
      int          r_stall;
      int          n;
      int          errors_before;
      op     = vec[idx*FIELDS];
      addr   = vec[idx*FIELDS+1];
      wd     = vec[idx*FIELDS+2];
      strb   = vec[idx*FIELDS+3];
      exp_rd = vec[idx*FIELDS+4];
      exp_rs = vec[idx*FIELDS+5];
      raddr  = vec[idx*FIELDS+6];
      // op 0 read, 1..3 write, 4 write with a read alongside
      need_aw = (op != 16'h0);
      need_w  = need_aw;
      need_ar = (op == 16'h0) || (op == 16'h4);
      need_b  = need_aw;
      need_r  = need_ar;
      // op 2 sends W late, op 3 sends AW late
      aw_dly  = (op == 16'h3) ? 1 : 0;
      w_dly   = (op == 16'h2) ? 1 : 0;
      b_stall = $random(seed) & 3;
      r_stall = $random(seed) & 3;
      n = 0;
      errors_before = errors;
      while (need_aw || need_w || need_ar || need_b || need_r) begin
         awvalid = need_aw && (n >= aw_dly);
         awaddr  = addr;
         wvalid  = need_w && (n >= w_dly);
         wdata   = wd;
         wstrb   = strb[1:0];
         arvalid = need_ar;
         araddr  = (op == 16'h4) ? raddr : addr;
         bready  = 1'b0;
         rready  = 1'b0;
         // ready only moves on the rising edge, so it is safe to look now
         if (awvalid && awready)
            need_aw = 1'b0;
         if (wvalid && wready)
            need_w = 1'b0;
         if (arvalid && arready)
            need_ar = 1'b0;
         if (bvalid) begin
            assert (need_b) else begin
               $display("test %0d: write response arrived that was not expected", idx);
               errors++;
            end
            if (need_b && b_stall > 0) begin
               b_stall--;
            end else begin
               bready = 1'b1;
               if (need_b)
                  assert (bresp == exp_rs[1:0])
                     else report_mismatch("bresp", 16'(bresp), exp_rs);
               need_b = 1'b0;
            end
         end
         if (rvalid) begin
            assert (need_r && !need_b) else begin
               $display("test %0d: read response arrived out of order or unasked", idx);
               errors++;
            end
            if (need_r && r_stall > 0) begin
               r_stall--;
            end else begin
               rready = 1'b1;
               if (need_r) begin
                  assert (rdata == exp_rd) else report_mismatch("rdata", rdata, exp_rd);
                  assert (rresp == exp_rs[1:0])
                     else report_mismatch("rresp", 16'(rresp), exp_rs);
               end
               need_r = 1'b0;
            end
         end
         @(negedge clk);
         n++;
      end
      awvalid = 1'b0;
      wvalid  = 1'b0;
      arvalid = 1'b0;
      bready  = 1'b0;
      rready  = 1'b0;
      if (errors == errors_before) begin
         pass_cnt++;
         $display("test %0d op %0h addr %h: ok", idx, op, addr);
      end else begin
         fail_cnt++;
         $display("test %0d op %0h addr %h: failed", idx, op, addr);
      end
   endtask

   initial begin
      clk     = 1'b0;
      rst     = 1'b1;
      awvalid = 1'b0;
      awaddr  = '0;
      wvalid  = 1'b0;
      wdata   = '0;
      wstrb   = '0;
      bready  = 1'b0;
      arvalid = 1'b0;
      araddr  = '0;
      rready  = 1'b0;
      $readmemh("verif/dmem_axil_tests.txt", vec);
      // vectors end at an op of ff
      ntests = 0;
      while (ntests < MAX_TESTS && vec[ntests*FIELDS] != 16'h00ff)
         ntests++;
      limit = 20 * ntests + 50;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      for (int i = 0; i < ntests; i++)
         run_test(i);
      assert (!bvalid && !rvalid) else begin
         $display("a response was left over after the last test");
         errors++;
      end
      $display("summary: %0d tests passed, %0d tests failed, %0d errors",
               pass_cnt, fail_cnt, errors);
      if (errors == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

endmodule

// File: verif/dmem_axil_props.sv
/*
 * concurrent assertions bound to the data memory top level
 * AXI valid/ready holding, reset values, issue versus queue room
 */

`timescale 1ns/1ps
`include "dmem_defs.svh"

module dmem_axil_props (
   input logic                       clk,
   input logic                       rst,
   input logic                       awvalid,
   input logic                       awready,
   input logic [`DMEM_ADDR_W-1:0]    awaddr,
   input logic                       wvalid,
   input logic                       wready,
   input logic [`DMEM_DATA_W-1:0]    wdata,
   input logic [`DMEM_DATA_W/8-1:0]  wstrb,
   input logic                       bvalid,
   input logic                       bready,
   input dmem_pkg::axi_resp_e        bresp,
   input logic                       arvalid,
   input logic                       arready,
   input logic [`DMEM_ADDR_W-1:0]    araddr,
   input logic                       rvalid,
   input logic                       rready,
   input logic [`DMEM_DATA_W-1:0]    rdata,
   input dmem_pkg::axi_resp_e        rresp,
   input logic                       req_valid,
   input logic                       space,
   input dmem_pkg::grant_e           last_grant
);

   // results issued to the memory and not yet taken by the master
   logic [2:0]  in_flight;
   logic        taken;

   assign taken = (bvalid && bready) || (rvalid && rready);

   always_ff @(posedge clk) begin
      if (rst)
         in_flight <= '0;
      else
         in_flight <= in_flight + 3'(req_valid) - 3'(taken);
   end

   ////////////////////////////////////////////////////////////
   // valid and payload hold until the beat
   ////////////////////////////////////////////////////////////

   aw_hold: assert property (@(posedge clk) disable iff (rst)
      awvalid && !awready |=> awvalid && $stable(awaddr))
      else $error("AW valid or address changed before ready");

   w_hold: assert property (@(posedge clk) disable iff (rst)
      wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
      else $error("W valid or payload changed before ready");

   ar_hold: assert property (@(posedge clk) disable iff (rst)
      arvalid && !arready |=> arvalid && $stable(araddr))
      else $error("AR valid or address changed before ready");

   // slave side response channels
   b_hold: assert property (@(posedge clk) disable iff (rst)
      bvalid && !bready |=> bvalid && $stable(bresp))
      else $error("B valid or response changed before ready");

   r_hold: assert property (@(posedge clk) disable iff (rst)
      rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
      else $error("R valid or payload changed before ready");

   // reset state
   rsp_reset: assert property (@(posedge clk) rst |=> !bvalid && !rvalid)
      else $error("response valid high during reset");

   grant_reset: assert property (@(posedge clk)
      rst |=> last_grant == dmem_pkg::grant_rd)
      else $error("arbiter grant not at read after reset");

   // space follows the room left by results still in flight
   space_room: assert property (@(posedge clk) disable iff (rst)
      space == (in_flight < `DMEM_RSP_DEPTH))
      else $error("space does not match the results still in flight");

   // queue full means nothing new goes to the memory
   issue_space: assert property (@(posedge clk) disable iff (rst)
      req_valid |-> in_flight < `DMEM_RSP_DEPTH)
      else $error("request issued while response queue had no space");

endmodule

// File: hdl/dmem_axil_top.sv
/*
 * AXI4-Lite data memory top level
 * front stage, byte memory and response stage
 */

`timescale 1ns/1ps
`include "dmem_defs.svh"

module dmem_axil_top (
   input  logic                       clk,
   input  logic                       rst,
   // write address
   input  logic                       awvalid,
   output logic                       awready,
   input  logic [`DMEM_ADDR_W-1:0]    awaddr,
   // write data
   input  logic                       wvalid,
   output logic                       wready,
   input  logic [`DMEM_DATA_W-1:0]    wdata,
   input  logic [`DMEM_DATA_W/8-1:0]  wstrb,
   // write response
   output logic                       bvalid,
   input  logic                       bready,
   output dmem_pkg::axi_resp_e        bresp,
   // read address
   input  logic                       arvalid,
   output logic                       arready,
   input  logic [`DMEM_ADDR_W-1:0]    araddr,
   // read data
   output logic                       rvalid,
   input  logic                       rready,
   output logic [`DMEM_DATA_W-1:0]    rdata,
   output dmem_pkg::axi_resp_e        rresp
);

   dmem_req_if req_i ();
   dmem_rsp_if rsp_i ();

   axil_req_stage req_stage_i (
      .clk     (clk),
      .rst     (rst),
      .awvalid (awvalid),
      .awready (awready),
      .awaddr  (awaddr),
      .wvalid  (wvalid),
      .wready  (wready),
      .wdata   (wdata),
      .wstrb   (wstrb),
      .arvalid (arvalid),
      .arready (arready),
      .araddr  (araddr),
      .req     (req_i.source),
      .space   (rsp_i.space)
   );

   byte_mem16 mem_i (
      .clk (clk),
      .rst (rst),
      .req (req_i.sink),
      .rsp (rsp_i.source)
   );

   axil_rsp_stage rsp_stage_i (
      .clk    (clk),
      .rst    (rst),
      .bvalid (bvalid),
      .bready (bready),
      .bresp  (bresp),
      .rvalid (rvalid),
      .rready (rready),
      .rdata  (rdata),
      .rresp  (rresp),
      .rsp    (rsp_i.sink)
   );

endmodule

// File: hdl/axil_rsp_stage.sv
/*
 * in-order response queue
 * drives the AXI B and R channels from the head entry
 */

`timescale 1ns/1ps
`include "dmem_defs.svh"

module axil_rsp_stage (
   input  logic                      clk,
   input  logic                      rst,
   output logic                      bvalid,
   input  logic                      bready,
   output dmem_pkg::axi_resp_e       bresp,
   output logic                      rvalid,
   input  logic                      rready,
   output logic [`DMEM_DATA_W-1:0]   rdata,
   output dmem_pkg::axi_resp_e       rresp,
   dmem_rsp_if.sink                  rsp
);

   localparam int DEPTH = `DMEM_RSP_DEPTH;
   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);

   // queue storage, no reset on payload
   dmem_pkg::mem_op_e         q_op    [DEPTH];
   logic [`DMEM_DATA_W-1:0]   q_rdata [DEPTH];
   dmem_pkg::axi_resp_e       q_resp  [DEPTH];

   logic [PTR_W-1:0]          head;
   logic [PTR_W-1:0]          tail;
   logic [CNT_W-1:0]          count;
   logic                      push;
   logic                      pop;

   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign push = rsp.valid;
   assign pop  = (bvalid && bready) || (rvalid && rready);

   // room for the stored results, the one arriving, and one more
   assign rsp.space = (int'(count) + int'(rsp.valid)) < DEPTH;

   // head entry goes to B or R by its op
   assign bvalid = (count != '0) && (q_op[head] == dmem_pkg::op_write);
   assign rvalid = (count != '0) && (q_op[head] == dmem_pkg::op_read);
   assign bresp  = q_resp[head];
   assign rresp  = q_resp[head];
   assign rdata  = q_rdata[head];

   always_ff @(posedge clk) begin
      if (rst) begin
         head  <= '0;
         tail  <= '0;
         count <= '0;
      end else begin
         if (push)
            tail <= ptr_inc(tail);
         if (pop)
            head <= ptr_inc(head);
         if (push && !pop)
            count <= count + 1'b1;
         else if (pop && !push)
            count <= count - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         q_op[tail]    <= rsp.op;
         q_rdata[tail] <= rsp.rdata;
         q_resp[tail]  <= rsp.resp;
      end
   end

endmodule

// File: hdl/byte_mem16.sv
/*
 * 64K byte array with big-endian 16-bit word access
 * strobed writes, top-of-space refusal, registered result
 */

`timescale 1ns/1ps
`include "dmem_defs.svh"

module byte_mem16 (
   input  logic        clk,
   input  logic        rst,
   dmem_req_if.sink    req,
   dmem_rsp_if.source  rsp
);

   logic [7:0]                mem [0:`DMEM_BYTES-1];

   logic [`DMEM_ADDR_W-1:0]   addr_next;
   logic                      wrap;
   logic [`DMEM_DATA_W-1:0]   rd_word;

   // memory comes up cleared
   initial begin
      for (int i = 0; i < `DMEM_BYTES; i++) begin
         mem[i] = 8'h00;
      end
   end

   // second byte of the word, wrap flagged below
   assign addr_next = req.addr + `DMEM_ADDR_W'(1);
   assign wrap      = (req.addr == '1);

   // combinational read, first byte is the high half
   assign rd_word = {mem[req.addr], mem[addr_next]};

   ////////////////////////////////////////////////////////////
   // byte writes
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      // refused writes leave the array untouched
      if (req.valid && req.op == dmem_pkg::op_write && !wrap) begin
         if (req.strb[1])
            mem[req.addr] <= req.wdata[15:8];
         if (req.strb[0])
            mem[addr_next] <= req.wdata[7:0];
      end
   end

   // result register
   always_ff @(posedge clk) begin
      if (rst)
         rsp.valid <= 1'b0;
      else
         rsp.valid <= req.valid;
   end

   always_ff @(posedge clk) begin
      rsp.op    <= req.op;
      rsp.resp  <= wrap ? dmem_pkg::rsp_slverr : dmem_pkg::rsp_okay;
      // zero data for writes and for refused reads
      rsp.rdata <= (req.op == dmem_pkg::op_read && !wrap) ? rd_word : '0;
   end

endmodule

// File: hdl/axil_req_stage.sv
/*
 * AXI4-Lite front stage
 * AW, W and AR holding registers with their ready outputs
 * read/write arbitration and request issue to the memory stage
 */

`timescale 1ns/1ps
`include "dmem_defs.svh"

module axil_req_stage (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       awvalid,
   output logic                       awready,
   input  logic [`DMEM_ADDR_W-1:0]    awaddr,
   input  logic                       wvalid,
   output logic                       wready,
   input  logic [`DMEM_DATA_W-1:0]    wdata,
   input  logic [`DMEM_DATA_W/8-1:0]  wstrb,
   input  logic                       arvalid,
   output logic                       arready,
   input  logic [`DMEM_ADDR_W-1:0]    araddr,
   dmem_req_if.source                 req,
   input  logic                       space
);

   // holding register state
   logic                       aw_full;
   logic                       w_full;
   logic                       ar_full;
   logic [`DMEM_ADDR_W-1:0]    awaddr_q;
   logic [`DMEM_ADDR_W-1:0]    araddr_q;
   logic [`DMEM_DATA_W-1:0]    wdata_q;
   logic [`DMEM_DATA_W/8-1:0]  wstrb_q;

   dmem_pkg::grant_e           last_grant;

   logic                       wr_ready;
   logic                       rd_ready;
   logic                       issue_wr;
   logic                       issue_rd;

   // each channel accepts a beat while its register is empty
   assign awready = !aw_full;
   assign wready  = !w_full;
   assign arready = !ar_full;

   ////////////////////////////////////////////////////////////
   // arbitration
   ////////////////////////////////////////////////////////////

   // a write needs both the address and the data half
   assign wr_ready = aw_full & w_full;
   assign rd_ready = ar_full;

   // on a tie the kind not served last goes first
   assign issue_wr = space & wr_ready &
                     (!rd_ready || last_grant == dmem_pkg::grant_rd);
   assign issue_rd = space & rd_ready & !issue_wr;

   // request presented straight from the holding registers
   always_comb begin
      req.valid = issue_wr | issue_rd;
      req.op    = issue_wr ? dmem_pkg::op_write : dmem_pkg::op_read;
      req.addr  = issue_wr ? awaddr_q : araddr_q;
      req.wdata = wdata_q;
      // reads carry no strobe
      req.strb  = issue_wr ? wstrb_q : '0;
   end

   ////////////////////////////////////////////////////////////
   // holding registers
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         aw_full    <= 1'b0;
         w_full     <= 1'b0;
         ar_full    <= 1'b0;
         last_grant <= dmem_pkg::grant_rd;
      end else begin
         // fill on handshake, empty on issue; both never coincide
         if (awvalid && awready)
            aw_full <= 1'b1;
         else if (issue_wr)
            aw_full <= 1'b0;

         if (wvalid && wready)
            w_full <= 1'b1;
         else if (issue_wr)
            w_full <= 1'b0;

         if (arvalid && arready)
            ar_full <= 1'b1;
         else if (issue_rd)
            ar_full <= 1'b0;

         if (issue_wr)
            last_grant <= dmem_pkg::grant_wr;
         else if (issue_rd)
            last_grant <= dmem_pkg::grant_rd;
      end
   end

   // payload captured on the accepting beat
   always_ff @(posedge clk) begin
      if (awvalid && awready)
         awaddr_q <= awaddr;
      if (wvalid && wready) begin
         wdata_q <= wdata;
         wstrb_q <= wstrb;
      end
      if (arvalid && arready)
         araddr_q <= araddr;
   end

endmodule

// File: hdl/dmem_rsp_if.sv
/*
 * result path from the memory stage to the response stage
 * space flows back from the response queue
 */

`timescale 1ns/1ps
`include "dmem_defs.svh"

interface dmem_rsp_if;

   logic                     valid;
   dmem_pkg::mem_op_e        op;
   logic [`DMEM_DATA_W-1:0]  rdata;
   dmem_pkg::axi_resp_e      resp;
   // queue has room for all results in flight plus one
   logic                     space;

   modport source (output valid, op, rdata, resp, input space);

   modport sink (input valid, op, rdata, resp, output space);

endinterface

// File: hdl/dmem_req_if.sv
/*
 * request path from the front stage to the memory stage
 * no ready, the memory takes every offered request
 */

`timescale 1ns/1ps
`include "dmem_defs.svh"

interface dmem_req_if;

   logic                       valid;
   dmem_pkg::mem_op_e          op;
   logic [`DMEM_ADDR_W-1:0]    addr;
   logic [`DMEM_DATA_W-1:0]    wdata;
   // bit 1 selects the byte at addr, bit 0 the byte at addr+1
   logic [`DMEM_DATA_W/8-1:0]  strb;

   // front stage side
   modport source (output valid, op, addr, wdata, strb);

   // memory stage side
   modport sink (input valid, op, addr, wdata, strb);

endinterface

// File: hdl/dmem_pkg.sv
/*
 * shared types for the data memory pipeline
 * operation, arbiter grant and AXI response encodings
 */

package dmem_pkg;

   // kind of access carried down the pipeline
   typedef enum logic {
      op_read  = 1'b0,
      op_write = 1'b1
   } mem_op_e;

   // kind of request served last by the front stage arbiter
   typedef enum logic {
      grant_rd = 1'b0,
      grant_wr = 1'b1
   } grant_e;

   // AXI BRESP / RRESP values, only OKAY and SLVERR are produced
   typedef enum logic [1:0] {
      rsp_okay   = 2'b00,
      rsp_slverr = 2'b10
   } axi_resp_e;

endpackage

// File: hdl/dmem_defs.svh
/*
 * sizing constants for the AXI4-Lite data memory
 * address and data widths, byte count, response queue depth
 */

`ifndef DMEM_DEFS_SVH
`define DMEM_DEFS_SVH

// byte address, one 64K byte space
`define DMEM_ADDR_W 16

// word width, two bytes per access
`define DMEM_DATA_W 16

// number of byte locations in the array
`define DMEM_BYTES 65536

// results the response stage can hold
`define DMEM_RSP_DEPTH 2

`endif
